// ==== hw/csa_feed_top.sv ====
`timescale 1ns/1ps

module csa_feed_top #(
	parameter int fifo_depth = 64
) (
	input  logic                axis_s_rclk,
	input  logic                rst_n,

	input  logic                in_wen,
	input  csa_pkg::in_word_t   in_wdata,
	output logic                in_error_full,

	input  logic                out_ren,
	output csa_pkg::csa_word_t  out_rdata,
	output logic                out_r_ready,
	output logic                out_error_full,
	output logic                out_error_empty
);

	logic fill_ready;
	logic fill_ren;
	csa_pkg::in_word_t fill_rdata;

	logic pack_wen;
	csa_pkg::csa_word_t pack_wdata;

	// ready once a whole group of input words is waiting
	word_fifo #(
		.payload_t  (csa_pkg::in_word_t),
		.fifo_depth (fifo_depth),
		.bulk_size  (csa_pkg::group_in_words)
	) in_fifo (
		.axis_s_rclk (axis_s_rclk),
		.rst_n       (rst_n),
		.wen         (in_wen),
		.wdata       (in_wdata),
		.ren         (fill_ren),
		.rdata       (fill_rdata),
		.r_ready     (fill_ready),
		.error_full  (in_error_full),
		.error_empty () // converter never reads below five words
	);

	width_converter converter (
		.axis_s_rclk (axis_s_rclk),
		.rst_n       (rst_n),
		.fill_ready  (fill_ready),
		.fill_ren    (fill_ren),
		.fill_rdata  (fill_rdata),
		.pack_wen    (pack_wen),
		.pack_wdata  (pack_wdata)
	);

	word_fifo #(
		.payload_t  (csa_pkg::csa_word_t),
		.fifo_depth (fifo_depth),
		.bulk_size  (1)
	) out_fifo (
		.axis_s_rclk (axis_s_rclk),
		.rst_n       (rst_n),
		.wen         (pack_wen),
		.wdata       (pack_wdata),
		.ren         (out_ren),
		.rdata       (out_rdata),
		.r_ready     (out_r_ready),
		.error_full  (out_error_full),
		.error_empty (out_error_empty)
	);

endmodule

// ==== hw/csa_pkg.sv ====
package csa_pkg;

	// input side, one bus word per FIFO entry
	localparam int axi_data_width = 32;

	localparam int byte_width = 8;

	// the adder stage takes five bytes per operand word
	localparam int csa_in_bytes = 5;

	localparam int out_data_width = byte_width * csa_in_bytes;

	// five input words and four output words both hold 160 bits
	localparam int group_in_words = 5;
	localparam int group_out_words = 4;

	typedef logic [axi_data_width-1:0] in_word_t;

	typedef logic [out_data_width-1:0] csa_word_t;

endpackage

// ==== hw/width_converter.sv ====
`timescale 1ns/1ps

module width_converter (
	input  logic                axis_s_rclk,
	input  logic                rst_n,
	input  logic                fill_ready,
	output logic                fill_ren,
	input  csa_pkg::in_word_t   fill_rdata,
	output logic                pack_wen,
	output csa_pkg::csa_word_t  pack_wdata
);

	localparam int group_width = csa_pkg::group_in_words * csa_pkg::axi_data_width;
	localparam int rd_idx_w = $clog2(csa_pkg::group_in_words);
	localparam int wr_idx_w = $clog2(csa_pkg::group_out_words);

	typedef enum logic [1:0] {
		g_idle,
		g_capture,
		g_wait
	} gather_state_t;

	typedef enum logic {
		e_idle,
		e_write
	} emit_state_t;

	gather_state_t gather_state;
	emit_state_t emit_state;

	logic [group_width-1:0] buffer_q; // five input words, word 0 lowest
	logic [rd_idx_w-1:0] rd_idx;
	logic group_valid; // one-cycle handover pulse

	csa_pkg::csa_word_t slice_q [csa_pkg::group_out_words];
	logic [wr_idx_w-1:0] wr_idx;
	logic emit_busy;

	// held high from the latch edge until the fourth word is written
	assign emit_busy = (emit_state != e_idle);

	// gather side
	always_ff @(posedge axis_s_rclk) begin
		if (!rst_n) begin
			gather_state <= g_idle;
			fill_ren <= 1'b0;
			rd_idx <= '0;
			group_valid <= 1'b0;
		end else begin
			group_valid <= 1'b0;
			case (gather_state)
				g_idle: begin
					if (fill_ready) begin
						fill_ren <= 1'b1;
						rd_idx <= '0;
						gather_state <= g_capture;
					end
				end
				g_capture: begin
					// FIFO pops on this same edge
					if (rd_idx == rd_idx_w'(csa_pkg::group_in_words - 1)) begin
						fill_ren <= 1'b0;
						rd_idx <= '0;
						gather_state <= g_wait;
					end else begin
						rd_idx <= rd_idx + 1'b1;
					end
				end
				g_wait: begin
					if (!emit_busy) begin
						group_valid <= 1'b1;
						gather_state <= g_idle;
					end
				end
				default: begin
					gather_state <= g_idle;
				end
			endcase
		end
	end

	// group buffer
	always_ff @(posedge axis_s_rclk) begin
		if (gather_state == g_capture) begin
			buffer_q[rd_idx * csa_pkg::axi_data_width +: csa_pkg::axi_data_width] <= fill_rdata;
		end
	end

	// emit side
	always_ff @(posedge axis_s_rclk) begin
		if (!rst_n) begin
			emit_state <= e_idle;
			wr_idx <= '0;
			pack_wen <= 1'b0;
		end else begin
			pack_wen <= 1'b0;
			case (emit_state)
				e_idle: begin
					if (group_valid) begin
						wr_idx <= '0;
						emit_state <= e_write;
					end
				end
				e_write: begin
					pack_wen <= 1'b1;
					if (wr_idx == wr_idx_w'(csa_pkg::group_out_words - 1)) begin
						wr_idx <= '0;
						emit_state <= e_idle;
					end else begin
						wr_idx <= wr_idx + 1'b1;
					end
				end
				default: begin
					emit_state <= e_idle;
				end
			endcase
		end
	end

	// slice latch frees the group buffer for the next gather
	always_ff @(posedge axis_s_rclk) begin
		if (emit_state == e_idle && group_valid) begin
			for (int i = 0; i < csa_pkg::group_out_words; i++) begin
				slice_q[i] <= buffer_q[i * csa_pkg::out_data_width +: csa_pkg::out_data_width];
			end
		end
	end

	// output word, lowest slice first
	always_ff @(posedge axis_s_rclk) begin
		if (emit_state == e_write) begin
			pack_wdata <= slice_q[wr_idx];
		end
	end

endmodule

// ==== hw/word_fifo.sv ====
`timescale 1ns/1ps

module word_fifo #(
	parameter type payload_t = logic [31:0],
	parameter int fifo_depth = 64,
	parameter int bulk_size = 1
) (
	input  logic     axis_s_rclk,
	input  logic     rst_n,
	input  logic     wen,
	input  payload_t wdata,
	input  logic     ren,
	output payload_t rdata,
	output logic     r_ready,
	output logic     error_full,
	output logic     error_empty
);

	localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
	localparam int cnt_w = $clog2(fifo_depth + 1);

	payload_t mem [fifo_depth];

	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] count;

	logic full;
	logic empty;
	logic do_write;
	logic do_read;

	assign full = (count == cnt_w'(fifo_depth));
	assign empty = (count == '0);

	// misused strobes are dropped
	assign do_write = wen && !full;
	assign do_read = ren && !empty;

	assign rdata = mem[rd_ptr]; // show-ahead head word
	assign r_ready = (count >= cnt_w'(bulk_size)); // enough words for one burst

	// storage
	always_ff @(posedge axis_s_rclk) begin
		if (do_write) begin
			mem[wr_ptr] <= wdata;
		end
	end

	// write pointer
	always_ff @(posedge axis_s_rclk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
		end else if (do_write) begin
			if (wr_ptr == ptr_w'(fifo_depth - 1)) begin
				wr_ptr <= '0; // wrap
			end else begin
				wr_ptr <= wr_ptr + 1'b1;
			end
		end
	end

	// read pointer
	always_ff @(posedge axis_s_rclk) begin
		if (!rst_n) begin
			rd_ptr <= '0;
		end else if (do_read) begin
			if (rd_ptr == ptr_w'(fifo_depth - 1)) begin
				rd_ptr <= '0;
			end else begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	// occupancy
	always_ff @(posedge axis_s_rclk) begin
		if (!rst_n) begin
			count <= '0;
		end else begin
			case ({do_write, do_read})
				2'b10: begin
					count <= count + 1'b1;
				end
				2'b01: begin
					count <= count - 1'b1;
				end
				default: begin
					count <= count; // idle, or push and pop together
				end
			endcase
		end
	end

	// sticky misuse flags, cleared only by reset
	always_ff @(posedge axis_s_rclk) begin
		if (!rst_n) begin
			error_full <= 1'b0;
			error_empty <= 1'b0;
		end else begin
			if (wen && full) begin
				error_full <= 1'b1;
			end
			if (ren && empty) begin
				error_empty <= 1'b1;
			end
		end
	end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the csa feed testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
	--top-module tb_csa_feed \
	-f src.f \
	-o sim_csa_feed

sim_out=$(./obj_dir/sim_csa_feed)
echo "$sim_out"

if echo "$sim_out" | grep -q "TEST PASSED"; then
	exit 0
else
	exit 1
fi

// ==== src.f ====
hw/csa_pkg.sv
hw/word_fifo.sv
hw/width_converter.sv
hw/csa_feed_top.sv
test/csa_feed_checker.sv
test/tb_csa_feed.sv

// ==== test/csa_feed_checker.sv ====
`timescale 1ns/1ps

module csa_feed_checker #(
	parameter int fifo_depth = 64
) (
	input  logic               axis_s_rclk,
	input  logic               rst_n,
	input  logic               in_wen,
	input  csa_pkg::in_word_t  in_wdata,
	input  logic               in_error_full,
	input  logic               out_ren,
	input  csa_pkg::csa_word_t out_rdata,
	input  logic               out_r_ready,
	input  logic               out_error_full,
	input  logic               out_error_empty,
	input  logic               step_check,
	input  logic               exp_in_full,
	input  logic               exp_out_full,
	input  logic               exp_out_empty,
	output int                 error_count
);

	logic [csa_pkg::byte_width-1:0] byte_q [$]; // input byte stream with the lowest byte first
	csa_pkg::csa_word_t exp_q [$]; // model of the output FIFO contents
	int in_words;
	int errors = 0;

	assign error_count = errors;

	task automatic compare_bit(input string name, input logic exp_val, input logic act_val);
		if (act_val !== exp_val) begin
			$display("ERROR at %0t: %s expected %0b actual %0b", $time, name, exp_val, act_val);
			errors++;
		end
	endtask

	// cut one group of bytes into output words and drop what a full FIFO cannot take
	task automatic close_group();
		csa_pkg::csa_word_t word;
		for (int w = 0; w < csa_pkg::group_out_words; w++) begin
			word = '0;
			for (int b = 0; b < csa_pkg::csa_in_bytes; b++) begin
				word[b * csa_pkg::byte_width +: csa_pkg::byte_width] = byte_q.pop_front();
			end
			if (exp_q.size() < fifo_depth) begin
				exp_q.push_back(word);
			end
		end
	endtask

	always @(negedge axis_s_rclk) begin
		if (!rst_n) begin
			byte_q.delete();
			exp_q.delete();
			in_words = 0;
		end else begin
			// nothing can be ready before a whole group was written
			if (exp_q.size() == 0) begin
				compare_bit("out_r_ready", 1'b0, out_r_ready);
			end
			if (in_wen) begin
				for (int b = 0; b < csa_pkg::axi_data_width / csa_pkg::byte_width; b++) begin
					byte_q.push_back(in_wdata[b * csa_pkg::byte_width +: csa_pkg::byte_width]);
				end
				in_words++;
				if (in_words == csa_pkg::group_in_words) begin
					close_group();
					in_words = 0;
				end
			end
			if (out_ren && exp_q.size() != 0) begin
				if (out_rdata !== exp_q[0]) begin
					$display("ERROR at %0t: out_rdata expected %h actual %h",
						$time, exp_q[0], out_rdata);
					errors++;
				end
				void'(exp_q.pop_front());
			end
			if (step_check) begin
				compare_bit("in_error_full", exp_in_full, in_error_full);
				compare_bit("out_error_full", exp_out_full, out_error_full);
				compare_bit("out_error_empty", exp_out_empty, out_error_empty);
			end
		end
	end

endmodule

// ==== test/tb_csa_feed.sv ====
`timescale 1ns/1ps

module tb_csa_feed;

	localparam int fifo_depth = 64;
	localparam int clk_period = 40;
	localparam int drive_delay = 2;
	localparam int ready_timeout = 200; // cycles
	localparam int flag_timeout = 500;
	localparam int quiet_cycles = 100;
	localparam int num_steps = 12;

	localparam logic [1:0] step_write = 2'd0;
	localparam logic [1:0] step_read = 2'd1;
	localparam logic [1:0] step_read_empty = 2'd2;

	// expected in_error_full, out_error_full and out_error_empty after the step
	typedef struct packed {
		logic [1:0] kind;
		logic [7:0] count;
		logic [2:0] flags;
	} step_t;

	step_t steps [num_steps] = '{
		'{step_write, 8'd5, 3'b000}, // one group
		'{step_read, 8'd4, 3'b000},
		'{step_write, 8'd4, 3'b000}, // partial group stays inside
		'{step_write, 8'd1, 3'b000},
		'{step_read, 8'd4, 3'b000},
		'{step_write, 8'd15, 3'b000}, // consumer stalled
		'{step_read, 8'd12, 3'b000},
		'{step_read_empty, 8'd1, 3'b001},
		'{step_write, 8'd10, 3'b001},
		'{step_read, 8'd8, 3'b001}, // empty flag is sticky
		'{step_write, 8'd85, 3'b011}, // seventeen groups into 64 entries
		'{step_read, 8'd64, 3'b011}
	};

	logic axis_s_rclk;
	logic rst_n;
	logic in_wen;
	csa_pkg::in_word_t in_wdata;
	logic in_error_full;
	logic out_ren;
	csa_pkg::csa_word_t out_rdata;
	logic out_r_ready;
	logic out_error_full;
	logic out_error_empty;

	logic step_check;
	logic exp_in_full;
	logic exp_out_full;
	logic exp_out_empty;
	int check_errors;
	int partial; // words of an unfinished group
	bit timed_out;

	csa_feed_top #(.fifo_depth(fifo_depth)) UUT (
		.axis_s_rclk     (axis_s_rclk),
		.rst_n           (rst_n),
		.in_wen          (in_wen),
		.in_wdata        (in_wdata),
		.in_error_full   (in_error_full),
		.out_ren         (out_ren),
		.out_rdata       (out_rdata),
		.out_r_ready     (out_r_ready),
		.out_error_full  (out_error_full),
		.out_error_empty (out_error_empty)
	);

	csa_feed_checker #(.fifo_depth(fifo_depth)) scoreboard (
		.axis_s_rclk     (axis_s_rclk),
		.rst_n           (rst_n),
		.in_wen          (in_wen),
		.in_wdata        (in_wdata),
		.in_error_full   (in_error_full),
		.out_ren         (out_ren),
		.out_rdata       (out_rdata),
		.out_r_ready     (out_r_ready),
		.out_error_full  (out_error_full),
		.out_error_empty (out_error_empty),
		.step_check      (step_check),
		.exp_in_full     (exp_in_full),
		.exp_out_full    (exp_out_full),
		.exp_out_empty   (exp_out_empty),
		.error_count     (check_errors)
	);

	initial begin
		axis_s_rclk = 1'b0;
		forever #(clk_period / 2) axis_s_rclk = ~axis_s_rclk;
	end

	task automatic next_cycle();
		@(posedge axis_s_rclk);
		#drive_delay;
	endtask

	task automatic write_words(input int n);
		for (int i = 0; i < n; i++) begin
			in_wen = 1'b1;
			in_wdata = $urandom();
			next_cycle();
		end
		in_wen = 1'b0;
		partial = (partial + n) % csa_pkg::group_in_words;
	endtask

	task automatic read_words(input int n);
		int waited;
		for (int i = 0; i < n; i++) begin
			waited = 0;
			while (out_r_ready !== 1'b1) begin
				if (waited == ready_timeout) begin
					$display("Timeout: no output word became ready for read %0d at %0t", i, $time);
					timed_out = 1'b1;
					out_ren = 1'b0;
					return;
				end
				out_ren = 1'b0;
				next_cycle();
				waited++;
			end
			out_ren = 1'b1;
			next_cycle();
		end
		out_ren = 1'b0;
	endtask

	task automatic read_empty();
		out_ren = 1'b1;
		next_cycle();
		out_ren = 1'b0;
	endtask

	task automatic wait_out_full();
		int waited;
		waited = 0;
		while (out_error_full !== 1'b1) begin
			if (waited == flag_timeout) begin
				$display("Timeout: the output FIFO never reported an overflow at %0t", $time);
				timed_out = 1'b1;
				return;
			end
			next_cycle();
			waited++;
		end
		// rest of the last group follows on consecutive cycles
		for (int i = 0; i < csa_pkg::group_out_words; i++) begin
			next_cycle();
		end
	endtask

	task automatic hold_quiet();
		for (int i = 0; i < quiet_cycles; i++) begin
			next_cycle(); // scoreboard watches out_r_ready meanwhile
		end
	endtask

	task automatic end_step(input logic [2:0] flags);
		{exp_in_full, exp_out_full, exp_out_empty} = flags;
		step_check = 1'b1;
		next_cycle();
		step_check = 1'b0;
	endtask

	initial begin
		rst_n = 1'b0;
		in_wen = 1'b0;
		in_wdata = '0;
		out_ren = 1'b0;
		step_check = 1'b0;
		exp_in_full = 1'b0;
		exp_out_full = 1'b0;
		exp_out_empty = 1'b0;
		partial = 0;
		timed_out = 1'b0;
		void'($urandom(82));

		repeat (16) @(posedge axis_s_rclk);
		#drive_delay;
		rst_n = 1'b1;
		end_step(3'b000);

		for (int s = 0; s < num_steps && !timed_out; s++) begin
			case (steps[s].kind)
				step_write: begin
					write_words(int'(steps[s].count));
					if (steps[s].flags[1]) begin
						wait_out_full();
					end else if (partial != 0) begin
						hold_quiet();
					end
				end
				step_read: begin
					read_words(int'(steps[s].count));
				end
				default: begin
					read_empty();
				end
			endcase
			if (!timed_out) begin
				end_step(steps[s].flags);
			end
		end
		next_cycle();

		$display("checker errors: %0d, timeouts: %0d", check_errors, timed_out);
		if (check_errors == 0 && !timed_out) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule
